// ==== sources.f ====
rtl/warpPkg.sv
rtl/instrDecoder.sv
rtl/instrBuffer.sv
rtl/issueScoreboard.sv
rtl/warpIssueTop.sv
tests/warpIssue_chk.sv
tests/warpIssueTb.sv

// ==== tests/warpIssueTb.sv ====
`timescale 1ns/1ps

module warpIssueTb
    import warpPkg::*;
();

    logic       clk;
    logic       rst;
    logic       fetchValid;
    instrT      fetchInstr;
    threadMaskT fetchMask;
    logic       fetchReady;
    logic       memFbValid;
    threadMaskT memFbMask;
    logic       memMissDone;
    logic       wbValid;
    scbIdT      wbScbId;
    logic       ocFull;
    logic       issueValid;
    instrT      issueInstr;
    threadMaskT issueMask;
    regIdT      issueDst;
    scbIdT      issueScbId;
    logic       issueReplay;

    // reference model state
    instrT                progQ [$];
    threadMaskT           progMaskQ [$];
    logic                 resValid;
    logic                 resReplay;
    instrT                resInstr;
    threadMaskT           resMask;
    scbIdT                resSlot;
    logic [SCB_DEPTH-1:0] slotValid;
    regIdT                slotDst [SCB_DEPTH];
    int                   issueCount;

    warpIssueTop warpIssueTop_i (
        .clk         (clk),
        .rst         (rst),
        .fetchValid  (fetchValid),
        .fetchInstr  (fetchInstr),
        .fetchMask   (fetchMask),
        .fetchReady  (fetchReady),
        .memFbValid  (memFbValid),
        .memFbMask   (memFbMask),
        .memMissDone (memMissDone),
        .wbValid     (wbValid),
        .wbScbId     (wbScbId),
        .ocFull      (ocFull),
        .issueValid  (issueValid),
        .issueInstr  (issueInstr),
        .issueMask   (issueMask),
        .issueDst    (issueDst),
        .issueScbId  (issueScbId),
        .issueReplay (issueReplay)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            stopRun($sformatf("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp));
        end
    endtask

    ////////////////////
    // reference model
    ////////////////////

    // bits are src1 used, src2 used, register write, memory op
    function automatic logic [3:0] opFlags(input instrT ins);
        case (ins[OPC_HI:OPC_LO])
            OP_ADD, OP_SUB: return 4'b1110;
            OP_ADDI:        return 4'b1010;
            OP_LOAD:        return 4'b1011;
            OP_STORE:       return 4'b1101;
            default:        return 4'b0000;
        endcase
    endfunction

    function automatic logic isPending(input regIdT r);
        for (int i = 0; i < SCB_DEPTH; i++) begin
            if (slotValid[i] && slotDst[i] == r) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic scbIdT lowestFree();
        for (int i = 0; i < SCB_DEPTH; i++) begin
            if (!slotValid[i]) begin
                return scbIdT'(i);
            end
        end
        return '0;
    endfunction

    // next issue allowed by the rules, and what it must carry
    function automatic logic refIssue(output instrT eInstr, output threadMaskT eMask,
                                      output logic eReplay, output scbIdT eScb,
                                      output logic scbKnown);
        logic [3:0] f;
        logic       hazard;
        eInstr   = '0;
        eMask    = '0;
        eReplay  = 1'b0;
        eScb     = lowestFree();
        scbKnown = 1'b0;
        if (resValid && resReplay) begin
            f        = opFlags(resInstr);
            eInstr   = resInstr;
            eMask    = resMask;
            eReplay  = 1'b1;
            eScb     = resSlot;
            scbKnown = f[1];
            return 1'b1;
        end
        if (progQ.size() == 0) begin
            return 1'b0;
        end
        eInstr   = progQ[0];
        eMask    = progMaskQ[0];
        f        = opFlags(eInstr);
        scbKnown = f[1];
        hazard   = (f[3] && isPending(eInstr[SRC1_HI:SRC1_LO])) ||
                   (f[2] && isPending(eInstr[SRC2_HI:SRC2_LO])) ||
                   (f[1] && isPending(eInstr[DST_HI:DST_LO]));
        // only one memory op may be resident
        if (resValid && f[0]) begin
            return 1'b0;
        end
        return !hazard && !(f[1] && (&slotValid));
    endfunction

    function automatic logic drained();
        return progQ.size() == 0 && !resValid && slotValid == '0;
    endfunction

    // samples at the edge, compares once the issue registers settled
    initial begin
        logic       capWb;
        scbIdT      capWbId;
        logic       capFb;
        threadMaskT capFbMask;
        logic       capMiss;
        logic       capFetch;
        instrT      capInstr;
        threadMaskT capMask;
        logic       capOc;
        logic       ok;
        instrT      eInstr;
        threadMaskT eMask;
        logic       eReplay;
        scbIdT      eScb;
        logic       scbKnown;
        logic [3:0] f;
        forever begin
            @(posedge clk);
            capWb     = wbValid;
            capWbId   = wbScbId;
            capFb     = memFbValid;
            capFbMask = memFbMask;
            capMiss   = memMissDone;
            capFetch  = fetchValid;
            capInstr  = fetchInstr;
            capMask   = fetchMask;
            capOc     = ocFull;
            #1;
            if (warpIssueTop_i.warpIssueChk_i.failCount != 0) begin
                stopRun("a bound assertion on the issue slice failed");
            end
            if (issueValid === 1'b1) begin
                ok = refIssue(eInstr, eMask, eReplay, eScb, scbKnown);
                checkEq(ok, 1'b1, "issue allowed by reference");
                checkEq(capOc, 1'b0, "ocFull in grant cycle");
                checkEq(issueInstr, eInstr, "issueInstr");
                checkEq(issueMask, eMask, "issueMask");
                checkEq(issueDst, eInstr[DST_HI:DST_LO], "issueDst");
                checkEq(issueReplay, eReplay, "issueReplay");
                if (scbKnown) begin
                    checkEq(issueScbId, eScb, "issueScbId");
                end
                issueCount++;
                f = opFlags(eInstr);
                if (eReplay) begin
                    resReplay = 1'b0;
                end else begin
                    void'(progQ.pop_front());
                    void'(progMaskQ.pop_front());
                    if (f[0]) begin
                        resValid  = 1'b1;
                        resReplay = 1'b0;
                        resInstr  = eInstr;
                        resMask   = eMask;
                        resSlot   = eScb;
                    end
                    if (f[1]) begin
                        slotValid[eScb] = 1'b1;
                        slotDst[eScb]   = eInstr[DST_HI:DST_LO];
                    end
                end
            end
            // effects of the same cycle land after its grant
            if (capWb) begin
                slotValid[capWbId] = 1'b0;
            end
            if (resValid && (capFb || capMiss)) begin
                if (capFb) begin
                    resMask = resMask & ~capFbMask;
                end
                if (capFb && resMask == '0) begin
                    resValid = 1'b0;
                end else begin
                    resReplay = 1'b1;
                end
            end
            if (capFetch && capInstr[OPC_HI:OPC_LO] != OP_NOP) begin
                progQ.push_back(capInstr);
                progMaskQ.push_back(capMask);
            end
        end
    end

    ////////////////////
    // stimulus helpers
    ////////////////////
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #5;
        end
    endtask

    task automatic quietInputs();
        fetchValid  = 1'b0;
        wbValid     = 1'b0;
        memFbValid  = 1'b0;
        memMissDone = 1'b0;
        ocFull      = 1'b0;
    endtask

    task automatic sendInstr(input opcodeT opc, input regIdT dst, input regIdT s1,
                             input regIdT s2, input threadMaskT mask);
        int n;
        n = 0;
        while (!fetchReady && n < 60) begin
            idle(1);
            n++;
        end
        if (!fetchReady) begin
            stopRun("fetchReady stayed low, the buffer never accepted an instruction");
        end
        fetchValid = 1'b1;
        fetchInstr = {opc, dst, s1, s2, 13'h0};
        fetchMask  = mask;
        idle(1);
        fetchValid = 1'b0;
    endtask

    task automatic waitIssues(input int target);
        int n;
        n = 0;
        while (issueCount < target && n < 100) begin
            idle(1);
            n++;
        end
        if (issueCount < target) begin
            stopRun("timed out waiting for an expected issue");
        end
    endtask

    task automatic waitDrained();
        int n;
        n = 0;
        while ((progQ.size() != 0 || resValid) && n < 100) begin
            idle(1);
            n++;
        end
        if (progQ.size() != 0 || resValid) begin
            stopRun("timed out waiting for the buffer to drain");
        end
    endtask

    task automatic pulseWb(input scbIdT slot);
        wbValid = 1'b1;
        wbScbId = slot;
        idle(1);
        wbValid = 1'b0;
    endtask

    task automatic pulseFb(input threadMaskT mask, input logic miss);
        memFbValid  = !miss;
        memFbMask   = mask;
        memMissDone = miss;
        idle(1);
        memFbValid  = 1'b0;
        memMissDone = 1'b0;
    endtask

    task automatic freeSlots();
        for (int i = 0; i < SCB_DEPTH; i++) begin
            if (slotValid[i]) begin
                pulseWb(scbIdT'(i));
            end
        end
    endtask

    // mixed stream with random back-pressure, writeback and feedback
    task automatic randomPhase(input int count);
        int    sent;
        int    cyc;
        scbIdT slot;
        sent = 0;
        cyc  = 0;
        while (!(sent == count && drained()) && cyc < 8000) begin
            quietInputs();
            ocFull = ($urandom % 4) == 0;
            if (sent < count && fetchReady && ($urandom % 2) == 1) begin
                fetchValid = 1'b1;
                fetchInstr = {opcodeT'($urandom % 6), regIdT'($urandom % 8),
                              regIdT'($urandom % 8), regIdT'($urandom % 8), immT'($urandom)};
                fetchMask  = threadMaskT'($urandom % 255 + 1);
                sent++;
            end
            slot = scbIdT'($urandom);
            if (slotValid[slot] && !(resValid && resSlot == slot) && ($urandom % 3) == 0) begin
                wbValid = 1'b1;
                wbScbId = slot;
            end
            if (resValid && ($urandom % 3) == 0) begin
                if (($urandom % 4) == 0) begin
                    memMissDone = 1'b1;
                end else begin
                    memFbValid = 1'b1;
                    memFbMask  = threadMaskT'($urandom);
                end
            end
            idle(1);
            cyc++;
        end
        quietInputs();
        if (!(sent == count && drained())) begin
            stopRun("random stream did not drain in time");
        end
    endtask

    initial begin
        int seed;
        int base;
        seed = 36;
        void'($urandom(seed));
        rst  = 1'b0;
        quietInputs();
        fetchInstr = '0;
        fetchMask  = '0;
        wbScbId    = '0;
        memFbMask  = '0;
        resValid   = 1'b0;
        resReplay  = 1'b0;
        resInstr   = '0;
        resMask    = '0;
        resSlot    = '0;
        slotValid  = '0;
        issueCount = 0;
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b1;
        idle(1);
        checkEq(fetchReady, 1'b1, "fetchReady after reset");
        checkEq(issueValid, 1'b0, "issueValid after reset");

        // independent ALU ops, the NOP disappears
        base = issueCount;
        sendInstr(OP_ADD, 5'd1, 5'd10, 5'd11, 8'hFF);
        sendInstr(OP_NOP, 5'd2, 5'd0, 5'd0, 8'h0F);
        sendInstr(OP_ADDI, 5'd2, 5'd12, 5'd0, 8'h3C);
        sendInstr(OP_SUB, 5'd3, 5'd13, 5'd14, 8'h81);
        waitIssues(base + 3);
        idle(5);
        checkEq(issueCount, base + 3, "issue count with a NOP in the stream");
        freeSlots();

        // RAW stall until the producer slot is written back
        base = issueCount;
        sendInstr(OP_ADD, 5'd4, 5'd5, 5'd6, 8'hF0);
        sendInstr(OP_ADD, 5'd7, 5'd4, 5'd5, 8'h0F);
        waitIssues(base + 1);
        idle(10);
        checkEq(issueCount, base + 1, "issue count while dependent ADD waits");
        pulseWb(2'd0);
        waitIssues(base + 2);
        freeSlots();

        // partial feedback, the replay overtakes a younger ADD
        base = issueCount;
        sendInstr(OP_LOAD, 5'd8, 5'd9, 5'd0, 8'hFF);
        waitIssues(base + 1);
        ocFull = 1'b1;
        sendInstr(OP_ADD, 5'd10, 5'd11, 5'd12, 8'h55);
        pulseFb(8'h0F, 1'b0);
        idle(4);
        ocFull = 1'b0;
        waitIssues(base + 3);
        pulseFb(8'hF0, 1'b0);
        idle(6);
        checkEq(issueCount, base + 3, "issue count after full feedback");
        freeSlots();

        // cache miss served, replay with the same mask and slot
        base = issueCount;
        sendInstr(OP_LOAD, 5'd13, 5'd14, 5'd0, 8'h3C);
        waitIssues(base + 1);
        pulseFb(8'h00, 1'b1);
        waitIssues(base + 2);
        pulseFb(8'h3C, 1'b0);
        waitDrained();
        freeSlots();

        // back-pressure fills the buffer
        base   = issueCount;
        ocFull = 1'b1;
        sendInstr(OP_ADD, 5'd15, 5'd16, 5'd17, 8'h01);
        sendInstr(OP_SUB, 5'd18, 5'd19, 5'd20, 8'h02);
        sendInstr(OP_ADDI, 5'd21, 5'd22, 5'd0, 8'h04);
        checkEq(fetchReady, 1'b0, "fetchReady with three entries buffered");
        idle(20);
        checkEq(issueCount, base, "issue count while ocFull is high");
        ocFull = 1'b0;
        waitIssues(base + 3);
        freeSlots();

        randomPhase(200);
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== tests/warpIssue_chk.sv ====
`timescale 1ns/1ps

module warpIssue_chk (
    input logic clk,
    input logic rst,
    input logic fetchValid,
    input logic fetchReady,
    input logic ocFull,
    input logic scbGrant,
    input logic issueValid
);

    int failCount = 0;

    // one issue cycle per grant, no more
    issuePerGrant: assert property (
        @(posedge clk) disable iff (!rst) issueValid == $past(scbGrant)
    ) else begin
        failCount++;
        $error("issueValid does not follow the previous cycle's grant");
    end

    noGrantWhenFull: assert property (
        @(posedge clk) disable iff (!rst) ocFull |-> !scbGrant
    ) else begin
        failCount++;
        $error("grant taken while ocFull is high");
    end

    // first cycle out of reset
    quietAfterReset: assert property (
        @(posedge clk) $rose(rst) |-> (!issueValid && !scbGrant && fetchReady)
    ) else begin
        failCount++;
        $error("outputs not quiet after reset");
    end

    fetchOnlyWhenReady: assert property (
        @(posedge clk) disable iff (!rst) fetchValid |-> fetchReady
    ) else begin
        failCount++;
        $error("fetch strobe while fetchReady is low");
    end

endmodule

bind warpIssueTop warpIssue_chk warpIssueChk_i (
    .clk        (clk),
    .rst        (rst),
    .fetchValid (fetchValid),
    .fetchReady (fetchReady),
    .ocFull     (ocFull),
    .scbGrant   (scbGrant),
    .issueValid (issueValid)
);

// ==== rtl/warpIssueTop.sv ====
`timescale 1ns/1ps

module warpIssueTop
    import warpPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       fetchValid,
    input  instrT      fetchInstr,
    input  threadMaskT fetchMask,
    output logic       fetchReady,
    input  logic       memFbValid,
    input  threadMaskT memFbMask,
    input  logic       memMissDone,
    input  logic       wbValid,
    input  scbIdT      wbScbId,
    input  logic       ocFull,
    output logic       issueValid,
    output instrT      issueInstr,
    output threadMaskT issueMask,
    output regIdT      issueDst,
    output scbIdT      issueScbId,
    output logic       issueReplay
);

    // decoder to buffer
    logic       bufReady;
    logic       decValid;
    instrT      decInstr;
    threadMaskT decMask;
    regIdT      decSrc1;
    regIdT      decSrc2;
    regIdT      decDst;
    logic       decSrc1Valid;
    logic       decSrc2Valid;
    logic       decRegWrite;
    logic       decMemRead;
    logic       decMemWrite;

    // buffer to scoreboard
    logic       ibReq;
    logic       ibReplay;
    regIdT      ibSrc1;
    regIdT      ibSrc2;
    regIdT      ibDst;
    logic       ibSrc1Valid;
    logic       ibSrc2Valid;
    logic       ibRegWrite;
    instrT      ibInstr;
    threadMaskT ibMask;
    scbIdT      ibReplayScbId;
    logic       scbGrant;
    scbIdT      scbGrantId;

    instrDecoder instrDecoder_i (
        .clk          (clk),
        .rst          (rst),
        .fetchValid   (fetchValid),
        .fetchInstr   (fetchInstr),
        .fetchMask    (fetchMask),
        .fetchReady   (fetchReady),
        .bufReady     (bufReady),
        .decValid     (decValid),
        .decInstr     (decInstr),
        .decMask      (decMask),
        .decSrc1      (decSrc1),
        .decSrc1Valid (decSrc1Valid),
        .decSrc2      (decSrc2),
        .decSrc2Valid (decSrc2Valid),
        .decDst       (decDst),
        .decRegWrite  (decRegWrite),
        .decMemRead   (decMemRead),
        .decMemWrite  (decMemWrite)
    );

    instrBuffer instrBuffer_i (
        .clk           (clk),
        .rst           (rst),
        .decValid      (decValid),
        .decInstr      (decInstr),
        .decMask       (decMask),
        .decSrc1       (decSrc1),
        .decSrc1Valid  (decSrc1Valid),
        .decSrc2       (decSrc2),
        .decSrc2Valid  (decSrc2Valid),
        .decDst        (decDst),
        .decRegWrite   (decRegWrite),
        .decMemRead    (decMemRead),
        .decMemWrite   (decMemWrite),
        .bufReady      (bufReady),
        .ibReq         (ibReq),
        .ibReplay      (ibReplay),
        .ibSrc1        (ibSrc1),
        .ibSrc2        (ibSrc2),
        .ibDst         (ibDst),
        .ibSrc1Valid   (ibSrc1Valid),
        .ibSrc2Valid   (ibSrc2Valid),
        .ibRegWrite    (ibRegWrite),
        .ibInstr       (ibInstr),
        .ibMask        (ibMask),
        .ibReplayScbId (ibReplayScbId),
        .scbGrant      (scbGrant),
        .scbGrantId    (scbGrantId),
        .memFbValid    (memFbValid),
        .memFbMask     (memFbMask),
        .memMissDone   (memMissDone)
    );

    issueScoreboard issueScoreboard_i (
        .clk           (clk),
        .rst           (rst),
        .ibReq         (ibReq),
        .ibReplay      (ibReplay),
        .ibSrc1        (ibSrc1),
        .ibSrc2        (ibSrc2),
        .ibDst         (ibDst),
        .ibSrc1Valid   (ibSrc1Valid),
        .ibSrc2Valid   (ibSrc2Valid),
        .ibRegWrite    (ibRegWrite),
        .ibInstr       (ibInstr),
        .ibMask        (ibMask),
        .ibReplayScbId (ibReplayScbId),
        .scbGrant      (scbGrant),
        .scbGrantId    (scbGrantId),
        .ocFull        (ocFull),
        .wbValid       (wbValid),
        .wbScbId       (wbScbId),
        .issueValid    (issueValid),
        .issueInstr    (issueInstr),
        .issueMask     (issueMask),
        .issueDst      (issueDst),
        .issueScbId    (issueScbId),
        .issueReplay   (issueReplay)
    );

endmodule

// ==== rtl/issueScoreboard.sv ====
`timescale 1ns/1ps

module issueScoreboard
    import warpPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ibReq,
    input  logic       ibReplay,
    input  regIdT      ibSrc1,
    input  regIdT      ibSrc2,
    input  regIdT      ibDst,
    input  logic       ibSrc1Valid,
    input  logic       ibSrc2Valid,
    input  logic       ibRegWrite,
    input  instrT      ibInstr,
    input  threadMaskT ibMask,
    input  scbIdT      ibReplayScbId,
    output logic       scbGrant,
    output scbIdT      scbGrantId,
    input  logic       ocFull,
    input  logic       wbValid,
    input  scbIdT      wbScbId,
    output logic       issueValid,
    output instrT      issueInstr,
    output threadMaskT issueMask,
    output regIdT      issueDst,
    output scbIdT      issueScbId,
    output logic       issueReplay
);

    logic [SCB_DEPTH-1:0] slotValid;
    regIdT                slotDst [SCB_DEPTH];
    logic [SCB_DEPTH-1:0] hit;
    logic                 depend;
    logic                 scbFull;
    logic                 alloc;
    scbIdT                freeId;

    ////////////////////
    // hazard check
    ////////////////////
    always_comb begin
        for (int i = 0; i < SCB_DEPTH; i++) begin
            hit[i] = slotValid[i] &&
                     ((ibSrc1Valid && (ibSrc1 == slotDst[i])) ||
                      (ibSrc2Valid && (ibSrc2 == slotDst[i])) ||
                      (ibRegWrite  && (ibDst  == slotDst[i])));
        end
    end

    assign depend  = |hit;
    assign scbFull = &slotValid;

    // lowest free slot
    always_comb begin
        freeId = '0;
        for (int i = SCB_DEPTH - 1; i >= 0; i--) begin
            if (!slotValid[i]) begin
                freeId = scbIdT'(i);
            end
        end
    end

    // replays already own their slot
    assign scbGrant = ibReq && !ocFull &&
                      (ibReplay || (!depend && !(ibRegWrite && scbFull)));
    assign scbGrantId = ibReplay ? ibReplayScbId : freeId;
    assign alloc      = scbGrant && !ibReplay && ibRegWrite;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            slotValid <= '0;
        end else begin
            if (wbValid) begin
                slotValid[wbScbId] <= 1'b0;
            end
            if (alloc) begin
                slotValid[freeId] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            slotDst[freeId] <= ibDst;
        end
    end

    ////////////////////
    // issue port
    ////////////////////
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            issueValid <= 1'b0;
        end else begin
            issueValid <= scbGrant;
        end
    end

    always_ff @(posedge clk) begin
        if (scbGrant) begin
            issueInstr  <= ibInstr;
            issueMask   <= ibMask;
            issueDst    <= ibDst;
            issueScbId  <= scbGrantId;
            issueReplay <= ibReplay;
        end
    end

endmodule

// ==== rtl/instrBuffer.sv ====
`timescale 1ns/1ps

module instrBuffer
    import warpPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       decValid,
    input  instrT      decInstr,
    input  threadMaskT decMask,
    input  regIdT      decSrc1,
    input  logic       decSrc1Valid,
    input  regIdT      decSrc2,
    input  logic       decSrc2Valid,
    input  regIdT      decDst,
    input  logic       decRegWrite,
    input  logic       decMemRead,
    input  logic       decMemWrite,
    output logic       bufReady,
    output logic       ibReq,
    output logic       ibReplay,
    output regIdT      ibSrc1,
    output regIdT      ibSrc2,
    output regIdT      ibDst,
    output logic       ibSrc1Valid,
    output logic       ibSrc2Valid,
    output logic       ibRegWrite,
    output instrT      ibInstr,
    output threadMaskT ibMask,
    output scbIdT      ibReplayScbId,
    input  logic       scbGrant,
    input  scbIdT      scbGrantId,
    input  logic       memFbValid,
    input  threadMaskT memFbMask,
    input  logic       memMissDone
);

    // entry storage
    instrT      instrQ [IB_DEPTH];
    threadMaskT maskQ  [IB_DEPTH];
    regIdT      src1Q  [IB_DEPTH];
    regIdT      src2Q  [IB_DEPTH];
    regIdT      dstQ   [IB_DEPTH];
    scbIdT      scbIdQ [IB_DEPTH];
    logic [IB_DEPTH-1:0] src1ValidQ;
    logic [IB_DEPTH-1:0] src2ValidQ;
    logic [IB_DEPTH-1:0] regWriteQ;
    logic [IB_DEPTH-1:0] memOpQ;

    logic [IB_DEPTH-1:0] entryValid;
    logic [IB_DEPTH-1:0] entryValidNext;
    logic [IB_DEPTH-1:0] replayFlag;
    logic [IB_DEPTH-1:0] replayNext;

    ibPtrT      wp;
    ibPtrT      rp;
    ibPtrT      irp;
    ibPtrT      rpNext;
    ibPtrT      depth;
    ibIdxT      wpIdx;
    ibIdxT      rpIdx;
    ibIdxT      irpIdx;
    ibIdxT      selIdx;
    logic       resident;
    logic       rpReq;
    logic       irpReq;
    logic       rpGrant;
    logic       irpGrant;
    threadMaskT irpMaskNext;
    logic       fbRetire;
    logic       fbReplay;

    assign wpIdx  = ibIdxT'(wp);
    assign rpIdx  = ibIdxT'(rp);
    assign irpIdx = ibIdxT'(irp);

    // occupancy runs from the oldest resident entry
    assign depth = wp - irp;
    // count the instruction sitting in the decoder as well
    assign bufReady = (depth + ibPtrT'(decValid)) < ibPtrT'(IB_DEPTH - 1);

    // irp lags rp only while a memory entry waits for feedback
    assign resident = (rp != irp) && entryValid[irpIdx];

    ////////////////////
    // memory feedback
    ////////////////////
    assign irpMaskNext = maskQ[irpIdx] & ~memFbMask;
    assign fbRetire    = resident && memFbValid && (irpMaskNext == '0);
    assign fbReplay    = resident && !fbRetire && (memFbValid || memMissDone);

    ////////////////////
    // issue request
    ////////////////////
    always_comb begin
        rpReq  = 1'b0;
        irpReq = 1'b0;
        if (!resident) begin
            rpReq = entryValid[rpIdx];
        end else if (replayFlag[irpIdx]) begin
            // replay goes ahead of younger entries
            irpReq = 1'b1;
        end else begin
            // a second memory op holds until the resident one leaves
            rpReq = entryValid[rpIdx] && !memOpQ[rpIdx];
        end
    end

    assign ibReq    = rpReq || irpReq;
    assign ibReplay = irpReq;
    assign rpGrant  = rpReq && scbGrant;
    assign irpGrant = irpReq && scbGrant;
    assign rpNext   = rpGrant ? rp + ibPtrT'(1) : rp;

    always_comb begin
        entryValidNext = entryValid;
        replayNext     = replayFlag;
        if (decValid) begin
            entryValidNext[wpIdx] = 1'b1;
            replayNext[wpIdx]     = 1'b0;
        end
        // memory ops stay behind as the resident entry
        if (rpGrant && !memOpQ[rpIdx]) begin
            entryValidNext[rpIdx] = 1'b0;
        end
        if (irpGrant) begin
            replayNext[irpIdx] = 1'b0;
        end
        if (fbRetire) begin
            entryValidNext[irpIdx] = 1'b0;
        end
        // fresh feedback wins over a grant in the same cycle
        if (fbReplay) begin
            replayNext[irpIdx] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wp         <= '0;
            rp         <= '0;
            irp        <= '0;
            entryValid <= '0;
            replayFlag <= '0;
        end else begin
            wp         <= decValid ? wp + ibPtrT'(1) : wp;
            rp         <= rpNext;
            irp        <= entryValidNext[irpIdx] ? irp : rpNext;
            entryValid <= entryValidNext;
            replayFlag <= replayNext;
        end
    end

    always_ff @(posedge clk) begin
        if (decValid) begin
            instrQ[wpIdx]     <= decInstr;
            maskQ[wpIdx]      <= decMask;
            src1Q[wpIdx]      <= decSrc1;
            src2Q[wpIdx]      <= decSrc2;
            dstQ[wpIdx]       <= decDst;
            src1ValidQ[wpIdx] <= decSrc1Valid;
            src2ValidQ[wpIdx] <= decSrc2Valid;
            regWriteQ[wpIdx]  <= decRegWrite;
            memOpQ[wpIdx]     <= decMemRead || decMemWrite;
        end
        // completed threads leave the private mask
        if (resident && memFbValid) begin
            maskQ[irpIdx] <= irpMaskNext;
        end
        if (rpGrant) begin
            scbIdQ[rpIdx] <= scbGrantId;
        end
    end

    ////////////////////
    // outputs to scoreboard
    ////////////////////
    assign selIdx        = irpReq ? irpIdx : rpIdx;
    assign ibSrc1        = src1Q[selIdx];
    assign ibSrc2        = src2Q[selIdx];
    assign ibDst         = dstQ[selIdx];
    assign ibSrc1Valid   = src1ValidQ[selIdx];
    assign ibSrc2Valid   = src2ValidQ[selIdx];
    assign ibRegWrite    = regWriteQ[selIdx];
    assign ibInstr       = instrQ[selIdx];
    assign ibMask        = maskQ[selIdx];
    assign ibReplayScbId = scbIdQ[irpIdx];

endmodule

// ==== rtl/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder
    import warpPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       fetchValid,
    input  instrT      fetchInstr,
    input  threadMaskT fetchMask,
    output logic       fetchReady,
    input  logic       bufReady,
    output logic       decValid,
    output instrT      decInstr,
    output threadMaskT decMask,
    output regIdT      decSrc1,
    output logic       decSrc1Valid,
    output regIdT      decSrc2,
    output logic       decSrc2Valid,
    output regIdT      decDst,
    output logic       decRegWrite,
    output logic       decMemRead,
    output logic       decMemWrite
);

    opcodeT opcode;
    logic   keep;
    logic   useSrc1;
    logic   useSrc2;
    logic   regWrite;
    logic   memRead;
    logic   memWrite;

    // buffer already counts the instruction held in decValid
    assign fetchReady = bufReady;

    assign opcode = fetchInstr[OPC_HI:OPC_LO];

    // control flags by opcode
    always_comb begin
        keep     = 1'b1;
        useSrc1  = 1'b0;
        useSrc2  = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        case (opcode)
            OP_ADD, OP_SUB: begin
                useSrc1  = 1'b1;
                useSrc2  = 1'b1;
                regWrite = 1'b1;
            end
            OP_ADDI: begin
                useSrc1  = 1'b1;
                regWrite = 1'b1;
            end
            OP_LOAD: begin
                useSrc1  = 1'b1;
                regWrite = 1'b1;
                memRead  = 1'b1;
            end
            OP_STORE: begin
                useSrc1  = 1'b1;
                useSrc2  = 1'b1;
                memWrite = 1'b1;
            end
            // nop and unused opcodes are dropped here
            default: keep = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            decValid <= 1'b0;
        end else begin
            decValid <= fetchValid && keep;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchValid) begin
            decInstr     <= fetchInstr;
            decMask      <= fetchMask;
            decSrc1      <= fetchInstr[SRC1_HI:SRC1_LO];
            decSrc2      <= fetchInstr[SRC2_HI:SRC2_LO];
            decDst       <= fetchInstr[DST_HI:DST_LO];
            decSrc1Valid <= useSrc1;
            decSrc2Valid <= useSrc2;
            decRegWrite  <= regWrite;
            decMemRead   <= memRead;
            decMemWrite  <= memWrite;
        end
    end

endmodule

// ==== rtl/warpPkg.sv ====
package warpPkg;

    ////////////////////
    // sizes
    ////////////////////
    localparam int NUM_THREADS = 8;
    localparam int IB_DEPTH    = 4;
    localparam int SCB_DEPTH   = 4;

    ////////////////////
    // vector types
    ////////////////////
    typedef logic [31:0]                    instrT;
    typedef logic [4:0]                     regIdT;
    typedef logic [12:0]                    immT;
    typedef logic [3:0]                     opcodeT;
    typedef logic [NUM_THREADS-1:0]         threadMaskT;
    // pointer carries one wrap bit above the index
    typedef logic [$clog2(IB_DEPTH):0]      ibPtrT;
    typedef logic [$clog2(IB_DEPTH)-1:0]    ibIdxT;
    typedef logic [$clog2(SCB_DEPTH)-1:0]   scbIdT;

    ////////////////////
    // opcodes
    ////////////////////
    localparam opcodeT OP_NOP   = 4'h0;
    localparam opcodeT OP_ADD   = 4'h1;
    localparam opcodeT OP_SUB   = 4'h2;
    localparam opcodeT OP_ADDI  = 4'h3;
    localparam opcodeT OP_LOAD  = 4'h4;
    localparam opcodeT OP_STORE = 4'h5;

    // instruction field positions
    localparam int OPC_HI  = 31;
    localparam int OPC_LO  = 28;
    localparam int DST_HI  = 27;
    localparam int DST_LO  = 23;
    localparam int SRC1_HI = 22;
    localparam int SRC1_LO = 18;
    localparam int SRC2_HI = 17;
    localparam int SRC2_LO = 13;
    localparam int IMM_HI  = 12;
    localparam int IMM_LO  = 0;

endpackage
